// File: Bender.yml
package:
  name: dmem_ahb3lite

sources:
  - files:
      - hw/dmem_pkg.sv
      - hw/dmem_req_queue.sv
      - hw/dmem_nodcache_ctrl.sv
      - hw/biu_ahb3lite.sv
      - hw/dmem_ahb3lite_top.sv
  - target: test
    files:
      - bench/tb_dmem_assert.sv
      - bench/tb_dmem_ahb3lite.sv

// File: bench/tb_dmem_ahb3lite.sv
// Testbench for the data memory top with AHB-Lite master
// LCG load/store traffic against a waited AHB slave memory, responses
// checked in order against a shadow memory

`timescale 1ns/1ps
`default_nettype none

module tb_dmem_ahb3lite;
  import dmem_pkg::*;

  localparam logic [31:0] SEED = 32'hce3c;
  localparam int N_PAIRS  = 48;
  localparam int N_RANDOM = 240;
  localparam int N_ZERO   = 64;
  localparam int N_TXN    = 2 * N_PAIRS + N_RANDOM + N_ZERO;
  // Up to 5 cycles each, doubled for gaps and drains, plus reset
  localparam int TIMEOUT_CYCLES = N_TXN * 5 * 2 + 1000;

  typedef struct packed {
    dmem_rsp_t rsp;
    logic      chk_q;
  } exp_rsp_t;

  logic        clk_i;
  logic        arst_n_i;
  logic        dmem_req_i;
  dmem_req_t   dmem_req_d_i;
  logic        dmem_gnt_o;
  logic        dmem_ack_o;
  dmem_rsp_t   dmem_rsp_o;
  ahb_m2s_t    ahb_m_o;
  ahb_s2m_t    ahb_s_i;

  // Turns on the latency assertion and zero wait states
  logic        zero_wait;
  logic [31:0] stim_state;
  logic [31:0] slave_state;
  int          err_cnt;
  int          cycle_cnt;
  exp_rsp_t    exp_q[$];

  // Slave memory and its shadow
  logic [31:0] mem     [256];
  logic [31:0] ref_mem [256];

  // Slave data phase
  logic        sl_active;
  logic        sl_write;
  logic        sl_err;
  logic        sl_err_stage;
  logic [1:0]  sl_wait;
  logic [7:0]  sl_idx;
  logic [1:0]  sl_lo;
  logic [2:0]  sl_size;

  dmem_ahb3lite_top dut0 (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .dmem_req_i   ( dmem_req_i   ),
    .dmem_req_d_i ( dmem_req_d_i ),
    .dmem_gnt_o   ( dmem_gnt_o   ),
    .dmem_ack_o   ( dmem_ack_o   ),
    .dmem_rsp_o   ( dmem_rsp_o   ),
    .ahb_m_o      ( ahb_m_o      ),
    .ahb_s_i      ( ahb_s_i      ) );

  bind dmem_ahb3lite_top tb_dmem_assert assert0 (
    .clk_i       ( clk_i                       ),
    .arst_n_i    ( arst_n_i                    ),
    .req_i       ( dmem_req_i                  ),
    .req_d_i     ( dmem_req_d_i                ),
    .gnt_i       ( dmem_gnt_o                  ),
    .ack_i       ( dmem_ack_o                  ),
    .ahb_m_i     ( ahb_m_o                     ),
    .ahb_s_i     ( ahb_s_i                     ),
    .stb_ack_i   ( biu_stb_ack                 ),
    .biu_req_i   ( biu_req                     ),
    .zero_wait_i ( tb_dmem_ahb3lite.zero_wait  ) );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Byte lanes of an access
  function automatic logic [31:0] lane_mask(input logic [1:0] lo, input logic [2:0] size);
    case (size)
      BYTE:    return 32'h0000_00ff << (8 * lo);
      HWORD:   return 32'h0000_ffff << (16 * lo[1]);
      default: return 32'hffff_ffff;
    endcase
  endfunction

  function automatic logic [1:0] align_lo(input logic [1:0] lo, input biu_size_t size);
    case (size)
      BYTE:    return lo;
      HWORD:   return {lo[1], 1'b0};
      default: return 2'b00;
    endcase
  endfunction

  function automatic dmem_req_t make_req(input logic we, input biu_size_t size,
                                         input logic err, input logic [7:0] idx,
                                         input logic [1:0] lo, input logic lock,
                                         input logic [31:0] d);
    // Bit 12 selects the error region
    return '{adr: {19'd0, err, 2'b00, idx, lo}, size: size, we: we, lock: lock, d: d};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    err_cnt++;
    $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
  endtask

  // Expected response, taken in grant order
  task automatic record_expected(input dmem_req_t r);
    exp_rsp_t    e;
    logic        mis;
    logic [7:0]  idx;
    logic [31:0] m;
    mis = ((r.size == HWORD) && r.adr[0]) || ((r.size == WORD) && (r.adr[1:0] != 2'b00));
    idx = r.adr[9:2];
    m   = lane_mask(r.adr[1:0], r.size);
    e   = '0;
    if (mis)
      e.rsp.misaligned = 1'b1;
    else if (r.adr[12])
      e.rsp.err = 1'b1;
    else if (r.we)
      ref_mem[idx] = (ref_mem[idx] & ~m) | (r.d & m);
    else
    begin
      e.rsp.q = ref_mem[idx];
      e.chk_q = 1'b1;
    end
    exp_q.push_back(e);
  endtask

  // Called on a falling edge, returns one edge after the grant
  task automatic send_req(input dmem_req_t r);
    dmem_req_i   = 1'b1;
    dmem_req_d_i = r;
    while (!dmem_gnt_o)
      @(negedge clk_i);
    record_expected(r);
    @(negedge clk_i);
    dmem_req_i = 1'b0;
  endtask

  task automatic send_random(input logic allow_bad);
    logic [31:0] a;
    logic [31:0] b;
    biu_size_t   size;
    logic [1:0]  lo;
    stim_state = lcg_next(stim_state);
    a          = stim_state;
    stim_state = lcg_next(stim_state);
    b          = stim_state;
    size       = (a[17:16] == 2'd3) ? WORD : biu_size_t'(a[17:16]);
    lo         = allow_bad ? a[19:18] : align_lo(a[19:18], size);
    // Idle gap now and then
    if (allow_bad && (a[21:20] == 2'd0))
      @(negedge clk_i);
    send_req(make_req(a[22], size, allow_bad && (a[25:23] == 3'd0),
                      {3'd0, a[30:26]}, lo, a[31], b));
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0)
      @(negedge clk_i);
  endtask

  ////////////////////////////////////////
  // AHB slave memory
  ////////////////////////////////////////

  // Decides the coming edge from registered master outputs
  always @(negedge clk_i)
  begin
    if (!arst_n_i)
    begin
      sl_active = 1'b0;
      ahb_s_i   = '{hrdata: '0, hready: 1'b1, hresp: 1'b0};
    end
    else
    begin
      // Two-cycle error, otherwise counted wait states
      ahb_s_i.hresp  = sl_active && sl_err;
      ahb_s_i.hready = !sl_active || (sl_err ? sl_err_stage : (sl_wait == 2'd0));
      ahb_s_i.hrdata = sl_active ? mem[sl_idx] : '0;
      if (ahb_s_i.hready)
      begin
        if (sl_active && sl_write && !sl_err)
          mem[sl_idx] = (mem[sl_idx] & ~lane_mask(sl_lo, sl_size)) |
                        (ahb_m_o.hwdata & lane_mask(sl_lo, sl_size));
        sl_active    = ahb_m_o.hsel && (ahb_m_o.htrans == HTRANS_NONSEQ);
        sl_write     = ahb_m_o.hwrite;
        sl_err       = ahb_m_o.haddr[12];
        sl_err_stage = 1'b0;
        sl_idx       = ahb_m_o.haddr[9:2];
        sl_lo        = ahb_m_o.haddr[1:0];
        sl_size      = ahb_m_o.hsize;
        slave_state  = lcg_next(slave_state);
        sl_wait      = zero_wait ? 2'd0 : slave_state[17:16];
      end
      else if (sl_err)
        sl_err_stage = 1'b1;
      else
        sl_wait = sl_wait - 2'd1;
    end
  end

  ////////////////////////////////////////
  // Response check
  ////////////////////////////////////////

  always @(negedge clk_i)
  begin : check_ack
    exp_rsp_t e;
    if (arst_n_i && dmem_ack_o)
    begin
      if (exp_q.size() == 0)
      begin
        err_cnt++;
        $display("Acknowledge at %0t without an outstanding request", $time);
      end
      else
      begin
        e = exp_q.pop_front();
        if (e.chk_q)
        begin
          assert (dmem_rsp_o.q === e.rsp.q)
            else report_mismatch("dmem_rsp_o.q", dmem_rsp_o.q, e.rsp.q);
        end
        assert (dmem_rsp_o.err === e.rsp.err)
          else report_mismatch("dmem_rsp_o.err", 32'(dmem_rsp_o.err), 32'(e.rsp.err));
        assert (dmem_rsp_o.misaligned === e.rsp.misaligned)
          else report_mismatch("dmem_rsp_o.misaligned", 32'(dmem_rsp_o.misaligned),
                               32'(e.rsp.misaligned));
      end
    end
  end

  initial
  begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles with %0d responses outstanding",
             cycle_cnt, exp_q.size());
    $display("Errors: %0d response, %0d assertion", err_cnt, dut0.assert0.fail_cnt);
    $display("** FAIL **");
    $finish;
  end

  initial
  begin : main
    biu_size_t   size;
    logic [7:0]  idx;
    logic [31:0] d;
    clk_i        = 1'b0;
    arst_n_i     = 1'b0;
    dmem_req_i   = 1'b0;
    dmem_req_d_i = '0;
    ahb_s_i      = '{hrdata: '0, hready: 1'b1, hresp: 1'b0};
    zero_wait    = 1'b0;
    stim_state   = SEED;
    slave_state  = SEED;
    err_cnt      = 0;
    // Fill from the word index
    for (int i = 0; i < 256; i++)
    begin
      mem[i]     = {8'(i) ^ 8'h3c, ~8'(i), 8'(i), 8'(i) ^ 8'hce};
      ref_mem[i] = mem[i];
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);

    // Writes of each size, each followed by a word read
    for (int i = 0; i < N_PAIRS; i++)
    begin
      stim_state = lcg_next(stim_state);
      size       = biu_size_t'(i % 3);
      idx        = {4'd0, stim_state[21:18]};
      d          = lcg_next(stim_state);
      send_req(make_req(1'b1, size, 1'b0, idx, align_lo(stim_state[17:16], size),
                        1'b0, d));
      send_req(make_req(1'b0, WORD, 1'b0, idx, 2'b00, 1'b0, 32'd0));
    end

    // Mixed traffic with misaligned and error accesses
    for (int i = 0; i < N_RANDOM; i++)
      send_random(1'b1);
    wait_drain();

    // Back to back with a zero-wait slave
    zero_wait = 1'b1;
    @(negedge clk_i);
    for (int i = 0; i < N_ZERO; i++)
      send_random(1'b0);
    wait_drain();
    zero_wait = 1'b0;

    // Room for stray acknowledges
    repeat (8) @(negedge clk_i);
    $display("Errors: %0d response, %0d assertion", err_cnt, dut0.assert0.fail_cnt);
    if ((err_cnt == 0) && (dut0.assert0.fail_cnt == 0))
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/tb_dmem_assert.sv
// Bound checks for the data memory top
// AHB-Lite hold, lock and fixed codes, alignment on the bus,
// ack ordering and the fixed zero-wait latency

`timescale 1ns/1ps
`default_nettype none

module tb_dmem_assert
  import dmem_pkg::*;
(
  input wire logic      clk_i,
  input wire logic      arst_n_i,
  input wire logic      req_i,
  input wire dmem_req_t req_d_i,
  input wire logic      gnt_i,
  input wire logic      ack_i,
  input wire ahb_m2s_t  ahb_m_i,
  input wire ahb_s2m_t  ahb_s_i,
  input wire logic      stb_ack_i,
  input wire biu_req_t  biu_req_i,
  input wire logic      zero_wait_i
);

  // Failed assertions, summed into the closing line
  int          fail_cnt = 0;

  logic        seen_gnt_q;
  logic [15:0] gnt_cnt_q;
  logic [15:0] ack_cnt_q;
  logic        nonseq;
  logic        req_mis;

  assign nonseq = (ahb_m_i.htrans == HTRANS_NONSEQ);

  // Offered CPU request breaks the size alignment rule
  assign req_mis = ((req_d_i.size == HWORD) && req_d_i.adr[0]) ||
                   ((req_d_i.size == WORD) && (req_d_i.adr[1:0] != 2'b00));

  // Grants and acks so far
  always_ff @(posedge clk_i, negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      seen_gnt_q <= 1'b0;
      gnt_cnt_q  <= '0;
      ack_cnt_q  <= '0;
    end
    else
    begin
      if (req_i && gnt_i)
      begin
        seen_gnt_q <= 1'b1;
        gnt_cnt_q  <= gnt_cnt_q + 16'd1;
      end
      if (ack_i)
        ack_cnt_q <= ack_cnt_q + 16'd1;
    end
  end

  ////////////////////////////////////////
  // Properties
  ////////////////////////////////////////

  // Quiet bus and open grant until the first grant
  idle_before_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !seen_gnt_q |-> !nonseq && !ahb_m_i.hsel && !ack_i && gnt_i)
    else
    begin
      fail_cnt = fail_cnt + 1;
      $error("bus or ack active, or grant low, before first grant");
    end

  // Single data transfers only
  fixed_codes: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    nonseq |-> (ahb_m_i.hburst == HBURST_SINGLE) && (ahb_m_i.hprot == HPROT_DATA))
    else
    begin
      fail_cnt = fail_cnt + 1;
      $error("hburst or hprot differs from the fixed code");
    end

  // Misaligned requests never reach the bus
  aligned_on_bus: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    nonseq |-> !(((ahb_m_i.hsize == HWORD) && ahb_m_i.haddr[0]) ||
                 ((ahb_m_i.hsize == WORD) && (ahb_m_i.haddr[1:0] != 2'b00))))
    else
    begin
      fail_cnt = fail_cnt + 1;
      $error("misaligned address issued on the bus");
    end

  ack_after_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ack_i |-> (ack_cnt_q < gnt_cnt_q))
    else
    begin
      fail_cnt = fail_cnt + 1;
      $error("more acknowledges than grants");
    end

  // Address and data phase held through wait states
  hold_on_wait: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !ahb_s_i.hready |=> $stable(ahb_m_i.haddr) && $stable(ahb_m_i.htrans) &&
                        $stable(ahb_m_i.hsize) && $stable(ahb_m_i.hwrite) &&
                        $stable(ahb_m_i.hmastlock) && $stable(ahb_m_i.hwdata))
    else
    begin
      fail_cnt = fail_cnt + 1;
      $error("bus signals changed during a wait state");
    end

  lock_follows_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    stb_ack_i |=> ahb_m_i.hmastlock == $past(biu_req_i.lock))
    else
    begin
      fail_cnt = fail_cnt + 1;
      $error("hmastlock differs from request lock");
    end

  // Aligned grant to ack is four edges with a zero-wait slave
  zero_wait_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    zero_wait_i && req_i && gnt_i && !req_mis |-> ##4 ack_i)
    else
    begin
      fail_cnt = fail_cnt + 1;
      $error("zero-wait request not acknowledged in time");
    end

endmodule

`default_nettype wire

// File: dmem_ahb3lite.f
hw/dmem_pkg.sv
hw/dmem_req_queue.sv
hw/dmem_nodcache_ctrl.sv
hw/biu_ahb3lite.sv
hw/dmem_ahb3lite_top.sv
bench/tb_dmem_assert.sv
bench/tb_dmem_ahb3lite.sv

// File: hw/biu_ahb3lite.sv
// AHB-Lite bus interface unit
// Issues single NONSEQ transfers with the address phase of one
// request overlapping the data phase of the previous one

`timescale 1ns/1ps
`default_nettype none

module biu_ahb3lite
  import dmem_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     arst_n_i,

  // Controller side
  input  wire logic     biu_stb_i,
  input  wire biu_req_t biu_req_i,
  output      logic     biu_stb_ack_o,
  output      logic     biu_ack_o,
  output      biu_rsp_t biu_rsp_o,

  // AHB-Lite master port
  output      ahb_m2s_t ahb_m_o,
  input  wire ahb_s2m_t ahb_s_i
);

  // Address phase
  logic            ap_hsel_q;
  logic [1:0]      ap_htrans_q;
  logic            ap_hmastlock_q;
  logic [ALEN-1:0] ap_haddr_q;
  logic [2:0]      ap_hsize_q;
  logic            ap_hwrite_q;
  // Write data waiting for its data phase
  logic [XLEN-1:0] ap_wdata_q;

  // Data phase
  logic            dp_pending_q;
  logic            dp_we_q;
  logic [XLEN-1:0] dp_hwdata_q;

  logic            hready;

  assign hready = ahb_s_i.hready;

  ////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////

  // Request taken when the current address phase is accepted
  assign biu_stb_ack_o = biu_stb_i & hready;

  always_ff @(posedge clk_i, negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ap_hsel_q      <= 1'b0;
      ap_htrans_q    <= HTRANS_IDLE;
      ap_hmastlock_q <= 1'b0;
    end
    else if (hready)
    begin
      if (biu_stb_i)
      begin
        ap_hsel_q      <= 1'b1;
        ap_htrans_q    <= HTRANS_NONSEQ;
        ap_hmastlock_q <= biu_req_i.lock;
      end
      else
      begin
        ap_hsel_q      <= 1'b0;
        ap_htrans_q    <= HTRANS_IDLE;
        ap_hmastlock_q <= 1'b0;
      end
    end
  end

  // Payload only moves with a new request
  always_ff @(posedge clk_i)
  begin
    if (hready && biu_stb_i)
    begin
      ap_haddr_q  <= biu_req_i.adr;
      ap_hsize_q  <= biu_req_i.size;
      ap_hwrite_q <= biu_req_i.we;
      ap_wdata_q  <= biu_req_i.d;
    end
  end

  ////////////////////////////////////////
  // Data phase
  ////////////////////////////////////////

  // Pending when the accepted address phase was a real transfer
  always_ff @(posedge clk_i, negedge arst_n_i)
  begin
    if (!arst_n_i)
      dp_pending_q <= 1'b0;
    else if (hready)
      dp_pending_q <= (ap_htrans_q == HTRANS_NONSEQ);
  end

  // Held while the slave stretches the data phase
  always_ff @(posedge clk_i)
  begin
    if (hready)
    begin
      dp_we_q     <= ap_hwrite_q;
      dp_hwdata_q <= ap_wdata_q;
    end
  end

  // Data phase ends on hready, error only with hready
  assign biu_ack_o     = dp_pending_q & hready;
  assign biu_rsp_o.q   = dp_we_q ? '0 : ahb_s_i.hrdata;
  assign biu_rsp_o.err = ahb_s_i.hresp;

  ////////////////////////////////////////
  // Bus outputs
  ////////////////////////////////////////

  always_comb
  begin
    ahb_m_o.hsel      = ap_hsel_q;
    ahb_m_o.haddr     = ap_haddr_q;
    ahb_m_o.hwdata    = dp_hwdata_q;
    ahb_m_o.hwrite    = ap_hwrite_q;
    ahb_m_o.hsize     = ap_hsize_q;
    // Fixed burst and protection
    ahb_m_o.hburst    = HBURST_SINGLE;
    ahb_m_o.hprot     = HPROT_DATA;
    ahb_m_o.htrans    = ap_htrans_q;
    ahb_m_o.hmastlock = ap_hmastlock_q;
  end

endmodule

`default_nettype wire

// File: hw/dmem_ahb3lite_top.sv
// Data memory top with AHB-Lite master
// Connects the no-cache controller to the bus interface unit

`timescale 1ns/1ps
`default_nettype none

module dmem_ahb3lite_top
  import dmem_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      arst_n_i,

  // Load/store unit
  input  wire logic      dmem_req_i,
  input  wire dmem_req_t dmem_req_d_i,
  output      logic      dmem_gnt_o,
  output      logic      dmem_ack_o,
  output      dmem_rsp_t dmem_rsp_o,

  // AHB-Lite
  output      ahb_m2s_t  ahb_m_o,
  input  wire ahb_s2m_t  ahb_s_i
);

  // Controller to BIU
  logic     biu_stb;
  logic     biu_stb_ack;
  logic     biu_ack;
  biu_req_t biu_req;
  biu_rsp_t biu_rsp;

  dmem_nodcache_ctrl ctrl0 (
    .clk_i         ( clk_i        ),
    .arst_n_i      ( arst_n_i     ),
    .mem_req_i     ( dmem_req_i   ),
    .mem_req_d_i   ( dmem_req_d_i ),
    .mem_gnt_o     ( dmem_gnt_o   ),
    .mem_ack_o     ( dmem_ack_o   ),
    .mem_rsp_o     ( dmem_rsp_o   ),
    .biu_stb_o     ( biu_stb      ),
    .biu_req_o     ( biu_req      ),
    .biu_stb_ack_i ( biu_stb_ack  ),
    .biu_ack_i     ( biu_ack      ),
    .biu_rsp_i     ( biu_rsp      ) );

  biu_ahb3lite biu0 (
    .clk_i         ( clk_i        ),
    .arst_n_i      ( arst_n_i     ),
    .biu_stb_i     ( biu_stb      ),
    .biu_req_i     ( biu_req      ),
    .biu_stb_ack_o ( biu_stb_ack  ),
    .biu_ack_o     ( biu_ack      ),
    .biu_rsp_o     ( biu_rsp      ),
    .ahb_m_o       ( ahb_m_o      ),
    .ahb_s_i       ( ahb_s_i      ) );

endmodule

`default_nettype wire

// File: hw/dmem_nodcache_ctrl.sv
// Data memory controller without cache
// Checks alignment, grants and queues requests, strobes aligned
// ones to the BIU and returns one registered response per request

`timescale 1ns/1ps
`default_nettype none

module dmem_nodcache_ctrl
  import dmem_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      arst_n_i,

  // CPU side
  input  wire logic      mem_req_i,
  input  wire dmem_req_t mem_req_d_i,
  output      logic      mem_gnt_o,
  output      logic      mem_ack_o,
  output      dmem_rsp_t mem_rsp_o,

  // BIU side
  output      logic      biu_stb_o,
  output      biu_req_t  biu_req_o,
  input  wire logic      biu_stb_ack_i,
  input  wire logic      biu_ack_i,
  input  wire biu_rsp_t  biu_rsp_i
);

  logic      q_full;
  logic      q_empty;
  logic      q_push;
  logic      q_pop;
  dmem_req_t q_head;
  logic      q_head_mis;
  logic      mis_retire;
  // Bus requests launched but not yet acknowledged
  logic [1:0] outst_q;

  // HWORD needs bit 0 clear, WORD both low bits
  function automatic logic is_misaligned(input dmem_req_t r);
    case (r.size)
      HWORD:   return r.adr[0];
      WORD:    return |r.adr[1:0];
      default: return 1'b0;
    endcase
  endfunction

  ////////////////////////////////////////
  // Acceptance
  ////////////////////////////////////////

  assign mem_gnt_o = ~q_full;
  assign q_push    = mem_req_i & ~q_full;

  dmem_req_queue #(
    .DEPTH             ( QUEUE_DEPTH                ) )
  req_queue0 (
    .clk_i             ( clk_i                      ),
    .arst_n_i          ( arst_n_i                   ),
    .push_i            ( q_push                     ),
    .push_d_i          ( mem_req_d_i                ),
    .push_misaligned_i ( is_misaligned(mem_req_d_i) ),
    .pop_i             ( q_pop                      ),
    .full_o            ( q_full                     ),
    .empty_o           ( q_empty                    ),
    .head_o            ( q_head                     ),
    .head_misaligned_o ( q_head_mis                 ) );

  ////////////////////////////////////////
  // Dispatch
  ////////////////////////////////////////

  // Only aligned heads go to the bus
  assign biu_stb_o = ~q_empty & ~q_head_mis;
  assign biu_req_o = '{adr:  q_head.adr,
                       size: q_head.size,
                       we:   q_head.we,
                       lock: q_head.lock,
                       d:    q_head.d};

  // Misaligned head waits until the bus has drained, keeps order
  assign mis_retire = ~q_empty & q_head_mis & (outst_q == 2'd0);
  assign q_pop      = biu_stb_ack_i | mis_retire;

  always_ff @(posedge clk_i, negedge arst_n_i)
  begin
    if (!arst_n_i)
      outst_q <= 2'd0;
    else if (biu_stb_ack_i && !biu_ack_i)
      outst_q <= outst_q + 2'd1;
    else if (biu_ack_i && !biu_stb_ack_i)
      outst_q <= outst_q - 2'd1;
  end

  ////////////////////////////////////////
  // Response
  ////////////////////////////////////////

  // Bus ack and misaligned retire never coincide
  always_ff @(posedge clk_i, negedge arst_n_i)
  begin
    if (!arst_n_i)
      mem_ack_o <= 1'b0;
    else
      mem_ack_o <= biu_ack_i | mis_retire;
  end

  always_ff @(posedge clk_i)
  begin
    if (biu_ack_i)
    begin
      mem_rsp_o.q          <= biu_rsp_i.q;
      mem_rsp_o.err        <= biu_rsp_i.err;
      mem_rsp_o.misaligned <= 1'b0;
    end
    else
    begin
      // Misaligned access, no data
      mem_rsp_o.q          <= '0;
      mem_rsp_o.err        <= 1'b0;
      mem_rsp_o.misaligned <= mis_retire;
    end
  end

endmodule

`default_nettype wire

// File: hw/dmem_pkg.sv
// Data memory subsystem package
// Bus widths, AHB-Lite codes, transfer sizes and the packed request,
// response and bus structs shared by the controller, BIU and top

`default_nettype none

package dmem_pkg;

  ////////////////////////////////////////
  // Widths and constants
  ////////////////////////////////////////

  // CPU data and address widths
  localparam int XLEN = 32;
  localparam int ALEN = 32;

  // Only IDLE and NONSEQ are ever issued
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

  // Single transfers only, no bursts
  localparam logic [2:0] HBURST_SINGLE = 3'b000;

  // Data access, privileged, non-bufferable, non-cacheable
  localparam logic [3:0] HPROT_DATA = 4'b0011;

  // Outstanding requests held by the controller
  localparam int QUEUE_DEPTH = 2;

  // Encoded as AHB HSIZE
  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HWORD = 3'b001,
    WORD  = 3'b010
  } biu_size_t;

  ////////////////////////////////////////
  // CPU side
  ////////////////////////////////////////

  // Load/store request, 69 bits
  typedef struct packed {
    logic [ALEN-1:0] adr;
    biu_size_t       size;
    logic            we;
    logic            lock;
    logic [XLEN-1:0] d;
  } dmem_req_t;

  // Response, valid with ack
  typedef struct packed {
    logic [XLEN-1:0] q;
    logic            err;
    logic            misaligned;
  } dmem_rsp_t;

  ////////////////////////////////////////
  // Controller to BIU
  ////////////////////////////////////////

  // Same fields as the CPU request
  typedef struct packed {
    logic [ALEN-1:0] adr;
    biu_size_t       size;
    logic            we;
    logic            lock;
    logic [XLEN-1:0] d;
  } biu_req_t;

  // Read data and bus error
  typedef struct packed {
    logic [XLEN-1:0] q;
    logic            err;
  } biu_rsp_t;

  ////////////////////////////////////////
  // AHB-Lite
  ////////////////////////////////////////

  // Master outputs
  typedef struct packed {
    logic            hsel;
    logic [ALEN-1:0] haddr;
    logic [XLEN-1:0] hwdata;
    logic            hwrite;
    logic [2:0]      hsize;
    logic [2:0]      hburst;
    logic [3:0]      hprot;
    logic [1:0]      htrans;
    logic            hmastlock;
  } ahb_m2s_t;

  // Slave inputs
  typedef struct packed {
    logic [XLEN-1:0] hrdata;
    logic            hready;
    logic            hresp;
  } ahb_s2m_t;

endpackage

`default_nettype wire

// File: hw/dmem_req_queue.sv
// Request queue
// Circular buffer that keeps accepted data requests in order,
// each with the misaligned flag decided at acceptance

`timescale 1ns/1ps
`default_nettype none

module dmem_req_queue
  import dmem_pkg::*;
#(
  parameter int DEPTH = QUEUE_DEPTH
)
(
  input  wire logic      clk_i,
  input  wire logic      arst_n_i,
  input  wire logic      push_i,
  input  wire dmem_req_t push_d_i,
  input  wire logic      push_misaligned_i,
  input  wire logic      pop_i,
  output      logic      full_o,
  output      logic      empty_o,
  output      dmem_req_t head_o,
  output      logic      head_misaligned_o
);

  // Keep pointers at least one bit wide
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage
  dmem_req_t        req_mem [DEPTH];
  logic             mis_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;

  // Entries, written at the tail
  always_ff @(posedge clk_i)
  begin
    if (push_i)
    begin
      req_mem[wr_ptr_q] <= push_d_i;
      mis_mem[wr_ptr_q] <= push_misaligned_i;
    end
  end

  // Pointers wrap at DEPTH
  always_ff @(posedge clk_i, negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop_i)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      // Simultaneous push and pop leaves the count alone
      if (push_i && !pop_i)
        cnt_q <= cnt_q + 1'b1;
      else if (pop_i && !push_i)
        cnt_q <= cnt_q - 1'b1;
    end
  end

  // Status and head entry
  assign full_o            = (cnt_q == CNT_W'(DEPTH));
  assign empty_o           = (cnt_q == '0);
  assign head_o            = req_mem[rd_ptr_q];
  assign head_misaligned_o = mis_mem[rd_ptr_q];

endmodule

`default_nettype wire
